// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

   ////////////////////////////////////////
   // Major opcodes
   ////////////////////////////////////////
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   // Arithmetic funct3 values, shared by OP and OP-IMM
   localparam logic [2:0] F3_ADD  = 3'b000;
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_SLTU = 3'b011;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;

   localparam int F7_ALT_BIT = 5;  // SUB / SRA select inside funct7

   ////////////////////////////////////////
   // Instruction word in its six formats
   ////////////////////////////////////////
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm11_0;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm11_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm4_0;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic       imm12;
         logic [5:0] imm10_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm4_1;
         logic       imm11;
         logic [6:0] opcode;
      } b;
      struct packed {
         logic [19:0] imm31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
      struct packed {
         logic       imm20;
         logic [9:0] imm10_1;
         logic       imm11;
         logic [7:0] imm19_12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j;
   } rv_instr_u;

endpackage

// File: hdl/id_ctrl_pkg.sv
package id_ctrl_pkg;

   // Field widths of the control set
   localparam int ALU_OP_W  = 4;
   localparam int IMM_SRC_W = 3;
   localparam int WB_SEL_W  = 2;
   localparam int BJ_OP_W   = 2;

   ////////////////////////////////////////
   // ALU operations
   ////////////////////////////////////////
   localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
   localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
   localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
   localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
   localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
   localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
   localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
   localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
   localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
   localparam logic [ALU_OP_W-1:0] ALU_COPY_B = 4'd10;  // LUI passes operand B

   // Operand selects
   localparam logic OP1_RS1 = 1'b0;
   localparam logic OP1_PC  = 1'b1;
   localparam logic OP2_RS2 = 1'b0;
   localparam logic OP2_IMM = 1'b1;

   // Immediate formats
   localparam logic [IMM_SRC_W-1:0] IMM_I = 3'd0;
   localparam logic [IMM_SRC_W-1:0] IMM_S = 3'd1;
   localparam logic [IMM_SRC_W-1:0] IMM_B = 3'd2;
   localparam logic [IMM_SRC_W-1:0] IMM_U = 3'd3;
   localparam logic [IMM_SRC_W-1:0] IMM_J = 3'd4;

   // Writeback source
   localparam logic [WB_SEL_W-1:0] WB_ALU = 2'd0;
   localparam logic [WB_SEL_W-1:0] WB_MEM = 2'd1;
   localparam logic [WB_SEL_W-1:0] WB_PC4 = 2'd2;

   // Branch / jump kind
   localparam logic [BJ_OP_W-1:0] BJ_NONE   = 2'd0;
   localparam logic [BJ_OP_W-1:0] BJ_BRANCH = 2'd1;
   localparam logic [BJ_OP_W-1:0] BJ_JAL    = 2'd2;
   localparam logic [BJ_OP_W-1:0] BJ_JALR   = 2'd3;

endpackage

// File: hdl/id_bus_if.sv
`timescale 1ns/1ps

interface id_bus_if;

   logic [4:0]  rs1_label;
   logic [4:0]  rs2_label;
   logic [4:0]  rd_label;
   logic [31:0] rs1_value;
   logic [31:0] rs2_value;
   logic [31:0] imm;

   // Execute stage control set
   logic [id_ctrl_pkg::ALU_OP_W-1:0]  alu_op;
   logic                              op1_sel;
   logic                              op2_sel;
   logic [id_ctrl_pkg::WB_SEL_W-1:0]  wb_sel;
   logic                              reg_wr_en;
   logic                              is_load;
   logic                              is_store;
   logic [2:0]                        mem_funct3;
   logic [id_ctrl_pkg::BJ_OP_W-1:0]   branch_jump_op;
   logic [id_ctrl_pkg::IMM_SRC_W-1:0] imm_src;  // Decoder to imm_gen only

   modport dec_mp (
      output rs1_label, rs2_label, rd_label,
      output alu_op, op1_sel, op2_sel, wb_sel, reg_wr_en,
      output is_load, is_store, mem_funct3, branch_jump_op, imm_src
   );

   modport imm_mp (input imm_src, output imm);

   modport rf_mp (input rs1_label, rs2_label, output rs1_value, rs2_value);

   modport stage_mp (
      input rs1_label, rs2_label, rd_label, rs1_value, rs2_value, imm,
      input alu_op, op1_sel, op2_sel, wb_sel, reg_wr_en,
      input is_load, is_store, mem_funct3, branch_jump_op, imm_src
   );

endinterface

// File: hdl/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
   input  rv_isa_pkg::rv_instr_u instr_i,
   id_bus_if.dec_mp              bus
);

   logic                             is_reg_op;  // OP, not OP-IMM
   logic                             f7_alt;
   logic [id_ctrl_pkg::ALU_OP_W-1:0] arith_op;

   assign bus.rs1_label = instr_i.r.rs1;
   assign bus.rs2_label = instr_i.r.rs2;
   assign bus.rd_label  = instr_i.r.rd;

   assign is_reg_op = (instr_i.r.opcode == rv_isa_pkg::OPC_OP);
   assign f7_alt    = instr_i.r.funct7[rv_isa_pkg::F7_ALT_BIT];

   ////////////////////////////////////////
   // ALU op for OP and OP-IMM
   ////////////////////////////////////////
   always_comb begin
      case (instr_i.r.funct3)
         rv_isa_pkg::F3_ADD:  arith_op = (is_reg_op && f7_alt) ? id_ctrl_pkg::ALU_SUB
                                                               : id_ctrl_pkg::ALU_ADD;
         rv_isa_pkg::F3_SLL:  arith_op = id_ctrl_pkg::ALU_SLL;
         rv_isa_pkg::F3_SLT:  arith_op = id_ctrl_pkg::ALU_SLT;
         rv_isa_pkg::F3_SLTU: arith_op = id_ctrl_pkg::ALU_SLTU;
         rv_isa_pkg::F3_XOR:  arith_op = id_ctrl_pkg::ALU_XOR;
         rv_isa_pkg::F3_SR:   arith_op = f7_alt ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
         rv_isa_pkg::F3_OR:   arith_op = id_ctrl_pkg::ALU_OR;
         default:             arith_op = id_ctrl_pkg::ALU_AND;
      endcase
   end

   ////////////////////////////////////////
   // Opcode decode
   ////////////////////////////////////////
   always_comb begin
      bus.alu_op         = id_ctrl_pkg::ALU_ADD;
      bus.op1_sel        = id_ctrl_pkg::OP1_RS1;
      bus.op2_sel        = id_ctrl_pkg::OP2_IMM;  // All but OP and BRANCH
      bus.wb_sel         = id_ctrl_pkg::WB_ALU;
      bus.reg_wr_en      = 1'b1;
      bus.is_load        = 1'b0;
      bus.is_store       = 1'b0;
      bus.mem_funct3     = instr_i.r.funct3;
      bus.branch_jump_op = id_ctrl_pkg::BJ_NONE;
      bus.imm_src        = id_ctrl_pkg::IMM_I;
      case (instr_i.r.opcode)
         rv_isa_pkg::OPC_LUI: begin
            bus.alu_op  = id_ctrl_pkg::ALU_COPY_B;
            bus.imm_src = id_ctrl_pkg::IMM_U;
         end
         rv_isa_pkg::OPC_AUIPC: begin
            bus.op1_sel = id_ctrl_pkg::OP1_PC;
            bus.imm_src = id_ctrl_pkg::IMM_U;
         end
         rv_isa_pkg::OPC_JAL: begin
            bus.op1_sel        = id_ctrl_pkg::OP1_PC;
            bus.wb_sel         = id_ctrl_pkg::WB_PC4;  // Link address
            bus.branch_jump_op = id_ctrl_pkg::BJ_JAL;
            bus.imm_src        = id_ctrl_pkg::IMM_J;
         end
         rv_isa_pkg::OPC_JALR: begin
            bus.wb_sel         = id_ctrl_pkg::WB_PC4;
            bus.branch_jump_op = id_ctrl_pkg::BJ_JALR;
         end
         rv_isa_pkg::OPC_BRANCH: begin
            bus.op2_sel        = id_ctrl_pkg::OP2_RS2;  // Compare rs1 with rs2
            bus.reg_wr_en      = 1'b0;
            bus.branch_jump_op = id_ctrl_pkg::BJ_BRANCH;
            bus.imm_src        = id_ctrl_pkg::IMM_B;
         end
         rv_isa_pkg::OPC_LOAD: begin
            bus.wb_sel  = id_ctrl_pkg::WB_MEM;
            bus.is_load = 1'b1;
         end
         rv_isa_pkg::OPC_STORE: begin
            bus.reg_wr_en = 1'b0;
            bus.is_store  = 1'b1;
            bus.imm_src   = id_ctrl_pkg::IMM_S;
         end
         rv_isa_pkg::OPC_OPIMM: bus.alu_op = arith_op;
         rv_isa_pkg::OPC_OP: begin
            bus.alu_op  = arith_op;
            bus.op2_sel = id_ctrl_pkg::OP2_RS2;
         end
         default: begin
            // Unknown opcode, nothing reaches EX
            bus.op2_sel    = id_ctrl_pkg::OP2_RS2;
            bus.reg_wr_en  = 1'b0;
            bus.mem_funct3 = 3'b000;
         end
      endcase
   end

   // Memory side sees at most one request kind
   always_comb begin
      assert (!(bus.is_load && bus.is_store))
         else $error("main_decoder load and store raised together");
   end

endmodule

// File: hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
   input  rv_isa_pkg::rv_instr_u instr_i,
   id_bus_if.imm_mp              bus
);

   // Bit 31 of the word carries the sign in every signed format
   always_comb begin
      case (bus.imm_src)
         id_ctrl_pkg::IMM_I:
            bus.imm = {{20{instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
         id_ctrl_pkg::IMM_S:
            bus.imm = {{20{instr_i.s.imm11_5[6]}}, instr_i.s.imm11_5, instr_i.s.imm4_0};
         id_ctrl_pkg::IMM_B:
            bus.imm = {{20{instr_i.b.imm12}},
                       instr_i.b.imm11,
                       instr_i.b.imm10_5,
                       instr_i.b.imm4_1,
                       1'b0};  // Halfword aligned target
         id_ctrl_pkg::IMM_U:
            bus.imm = {instr_i.u.imm31_12, 12'h000};
         id_ctrl_pkg::IMM_J:
            bus.imm = {{12{instr_i.j.imm20}},
                       instr_i.j.imm19_12,
                       instr_i.j.imm11,
                       instr_i.j.imm10_1,
                       1'b0};
         default:
            bus.imm = 32'h0000_0000;
      endcase
   end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        rd_enable_i,
   input  logic [4:0]  rd_label_i,
   input  logic [31:0] rd_data_i,
   id_bus_if.rf_mp     bus
);

   logic [31:0] regs [32];
   logic        wr_valid;  // Write to a real register

   assign wr_valid = rd_enable_i && (rd_label_i != 5'd0);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int k = 0; k < 32; k++) begin
            regs[k] <= 32'h0000_0000;
         end
      end else if (wr_valid) begin
         regs[rd_label_i] <= rd_data_i;
      end
   end

   // Same cycle write seen by the reader
   // x0 keeps its reset zero since wr_valid never selects it
   assign bus.rs1_value = (wr_valid && rd_label_i == bus.rs1_label) ? rd_data_i :
                                                                      regs[bus.rs1_label];
   assign bus.rs2_value = (wr_valid && rd_label_i == bus.rs2_label) ? rd_data_i :
                                                                      regs[bus.rs2_label];

   a_x0_reads_zero : assert property (@(posedge clk_i) disable iff (rst_i)
      bus.rs1_label == 5'd0 |-> bus.rs1_value == 32'h0000_0000);

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
   input  logic                                    clk_i,
   input  logic                                    rst_i,
   input  logic                                    flush_i,
   input  logic                                    busywait_i,
   input  logic                                    stall_id_i,
   input  logic [31:0]                             pc_i,
   id_bus_if.stage_mp                              bus,
   output logic                                    load_stall_o,
   output logic [31:0]                             pc_o,
   output logic [31:0]                             rs1_value_o,
   output logic [31:0]                             rs2_value_o,
   output logic [31:0]                             imm_value_o,
   output logic [4:0]                              rd_o,
   output logic [4:0]                              rs1_label_o,
   output logic [4:0]                              rs2_label_o,
   output logic [id_ctrl_pkg::ALU_OP_W-1:0]        alu_op_o,
   output logic                                    alu_op1_sel_o,
   output logic                                    alu_op2_sel_o,
   output logic [id_ctrl_pkg::WB_SEL_W-1:0]        wb_sel_o,
   output logic                                    reg_wb_en_o,
   output logic                                    is_load_o,
   output logic                                    is_store_o,
   output logic [2:0]                              mem_funct3_o,
   output logic [id_ctrl_pkg::BJ_OP_W-1:0]         branch_jump_op_o
);

   logic bubble;   // Load-use stall turned into a NOP
   logic clear;
   logic capture;

   ////////////////////////////////////////
   // Load-use hazard against the EX slot
   ////////////////////////////////////////
   assign load_stall_o = is_load_o && (rd_o != 5'd0) &&
                         ((rd_o == bus.rs1_label) || (rd_o == bus.rs2_label));

   assign bubble  = !busywait_i && stall_id_i && load_stall_o;
   assign clear   = rst_i || flush_i || bubble;
   assign capture = !busywait_i && !stall_id_i;  // Otherwise hold

   always_ff @(posedge clk_i) begin
      if (clear) begin
         pc_o             <= '0;
         rs1_value_o      <= '0;
         rs2_value_o      <= '0;
         imm_value_o      <= '0;
         rd_o             <= '0;
         rs1_label_o      <= '0;
         rs2_label_o      <= '0;
         alu_op_o         <= '0;
         alu_op1_sel_o    <= 1'b0;
         alu_op2_sel_o    <= 1'b0;
         wb_sel_o         <= '0;
         reg_wb_en_o      <= 1'b0;
         is_load_o        <= 1'b0;
         is_store_o       <= 1'b0;
         mem_funct3_o     <= '0;
         branch_jump_op_o <= '0;
      end else if (capture) begin
         pc_o             <= pc_i;
         rs1_value_o      <= bus.rs1_value;
         rs2_value_o      <= bus.rs2_value;
         imm_value_o      <= bus.imm;
         rd_o             <= bus.rd_label;
         rs1_label_o      <= bus.rs1_label;
         rs2_label_o      <= bus.rs2_label;
         alu_op_o         <= bus.alu_op;
         alu_op1_sel_o    <= bus.op1_sel;
         alu_op2_sel_o    <= bus.op2_sel;
         wb_sel_o         <= bus.wb_sel;
         reg_wb_en_o      <= bus.reg_wr_en;
         is_load_o        <= bus.is_load;
         is_store_o       <= bus.is_store;
         mem_funct3_o     <= bus.mem_funct3;
         branch_jump_op_o <= bus.branch_jump_op;
      end
   end

   // A bubble must never write back in EX
   a_bubble_no_wb : assert property (@(posedge clk_i) disable iff (rst_i)
      bubble |=> !reg_wb_en_o);

endmodule

// File: hdl/instruction_decode_stage.sv
`timescale 1ns/1ps

module instruction_decode_stage (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic [31:0] instr_i,
   input  logic [31:0] pc_i,
   input  logic [31:0] rd_data_i,
   input  logic [4:0]  rd_label_i,
   input  logic        rd_enable_i,
   input  logic        stall_id_i,
   input  logic        busywait_i,
   input  logic        flush_i,
   output logic        load_stall_o,
   output logic [31:0] pc_o,
   output logic [31:0] rs1_value_o,
   output logic [31:0] rs2_value_o,
   output logic [31:0] imm_value_o,
   output logic [4:0]  rd_o,
   output logic [4:0]  rs1_label_o,
   output logic [4:0]  rs2_label_o,
   output logic [3:0]  alu_op_o,
   output logic        alu_op1_sel_o,
   output logic        alu_op2_sel_o,
   output logic [1:0]  wb_sel_o,
   output logic        reg_wb_en_o,
   output logic        is_load_o,
   output logic        is_store_o,
   output logic [2:0]  mem_funct3_o,
   output logic [1:0]  branch_jump_op_o
);

   rv_isa_pkg::rv_instr_u instr_word;  // Format views of instr_i

   assign instr_word = instr_i;

   id_bus_if id_bus ();

   main_decoder u_main_decoder (.instr_i(instr_word), .bus(id_bus.dec_mp));

   imm_gen u_imm_gen (.instr_i(instr_word), .bus(id_bus.imm_mp));

   regfile u_regfile (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .rd_enable_i (rd_enable_i),  // From writeback
      .rd_label_i  (rd_label_i),
      .rd_data_i   (rd_data_i),
      .bus         (id_bus.rf_mp)
   );

   id_ex_reg u_id_ex_reg (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .flush_i          (flush_i),
      .busywait_i       (busywait_i),
      .stall_id_i       (stall_id_i),
      .pc_i             (pc_i),
      .bus              (id_bus.stage_mp),
      .load_stall_o     (load_stall_o),
      .pc_o             (pc_o),
      .rs1_value_o      (rs1_value_o),
      .rs2_value_o      (rs2_value_o),
      .imm_value_o      (imm_value_o),
      .rd_o             (rd_o),
      .rs1_label_o      (rs1_label_o),
      .rs2_label_o      (rs2_label_o),
      .alu_op_o         (alu_op_o),
      .alu_op1_sel_o    (alu_op1_sel_o),
      .alu_op2_sel_o    (alu_op2_sel_o),
      .wb_sel_o         (wb_sel_o),
      .reg_wb_en_o      (reg_wb_en_o),
      .is_load_o        (is_load_o),
      .is_store_o       (is_store_o),
      .mem_funct3_o     (mem_funct3_o),
      .branch_jump_op_o (branch_jump_op_o)
   );

endmodule

// File: testbench/tb_instruction_decode_stage.sv
`timescale 1ns/1ps

module tb_instruction_decode_stage;

   localparam int SEED         = 2265;
   localparam int RESET_CYCLES = 10;
   localparam int RF_CYCLES    = 200;
   localparam int DEC_CYCLES   = 600;
   localparam int LU_ROUNDS    = 40;
   localparam int CTRL_CYCLES  = 600;
   localparam int TEST_CYCLES  = RESET_CYCLES + RF_CYCLES + DEC_CYCLES + 3 * LU_ROUNDS
                                 + CTRL_CYCLES + 40;
   localparam int TIMEOUT_NS   = TEST_CYCLES * 10 + 1000;

   // Expected contents of the ID/EX register
   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] rs1_value;
      logic [31:0] rs2_value;
      logic [31:0] imm;
      logic [4:0]  rd;
      logic [4:0]  rs1_label;
      logic [4:0]  rs2_label;
      logic [3:0]  alu_op;
      logic        op1_sel;
      logic        op2_sel;
      logic [1:0]  wb_sel;
      logic        reg_wb_en;
      logic        is_load;
      logic        is_store;
      logic [2:0]  mem_funct3;
      logic [1:0]  bj_op;
   } stage_out_t;

   logic        clk_i       = 1'b0;
   logic        rst_i       = 1'b1;
   logic [31:0] instr_i     = '0;
   logic [31:0] pc_i        = '0;
   logic [31:0] rd_data_i   = '0;
   logic [4:0]  rd_label_i  = '0;
   logic        rd_enable_i = 1'b0;
   logic        stall_id_i  = 1'b0;
   logic        busywait_i  = 1'b0;
   logic        flush_i     = 1'b0;
   logic        load_stall_o;
   logic [31:0] pc_o;
   logic [31:0] rs1_value_o;
   logic [31:0] rs2_value_o;
   logic [31:0] imm_value_o;
   logic [4:0]  rd_o;
   logic [4:0]  rs1_label_o;
   logic [4:0]  rs2_label_o;
   logic [3:0]  alu_op_o;
   logic        alu_op1_sel_o;
   logic        alu_op2_sel_o;
   logic [1:0]  wb_sel_o;
   logic        reg_wb_en_o;
   logic        is_load_o;
   logic        is_store_o;
   logic [2:0]  mem_funct3_o;
   logic [1:0]  branch_jump_op_o;

   stage_out_t  exp_out    = '0;
   logic        exp_hazard = 1'b0;
   logic        exp_valid  = 1'b0;
   logic [31:0] shadow [32];  // Register file model
   int          checks       = 0;
   int          value_errors = 0;
   int          other_errors = 0;

   instruction_decode_stage instruction_decode_stage_inst (.*);

   initial begin
      forever #5 clk_i = ~clk_i;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////
   function automatic stage_out_t ref_decode(input logic [31:0] ins, input logic [31:0] pc,
                                             input logic [31:0] regs [32]);
      stage_out_t e;
      logic [3:0] arith;
      e            = '0;
      e.pc         = pc;
      e.rs1_value  = (ins[19:15] == 5'd0) ? 32'd0 : regs[ins[19:15]];
      e.rs2_value  = (ins[24:20] == 5'd0) ? 32'd0 : regs[ins[24:20]];
      e.imm        = {{20{ins[31]}}, ins[31:20]};  // I format unless replaced
      e.rd         = ins[11:7];
      e.rs1_label  = ins[19:15];
      e.rs2_label  = ins[24:20];
      e.op2_sel    = 1'b1;
      e.reg_wb_en  = 1'b1;
      e.mem_funct3 = ins[14:12];
      case (ins[14:12])
         3'd0: arith = (ins[6:0] == rv_isa_pkg::OPC_OP && ins[30]) ? id_ctrl_pkg::ALU_SUB
                                                                   : id_ctrl_pkg::ALU_ADD;
         3'd1: arith = id_ctrl_pkg::ALU_SLL;
         3'd2: arith = id_ctrl_pkg::ALU_SLT;
         3'd3: arith = id_ctrl_pkg::ALU_SLTU;
         3'd4: arith = id_ctrl_pkg::ALU_XOR;
         3'd5: arith = ins[30] ? id_ctrl_pkg::ALU_SRA : id_ctrl_pkg::ALU_SRL;
         3'd6: arith = id_ctrl_pkg::ALU_OR;
         default: arith = id_ctrl_pkg::ALU_AND;
      endcase
      case (ins[6:0])
         rv_isa_pkg::OPC_LUI: begin
            e.alu_op = id_ctrl_pkg::ALU_COPY_B;
            e.imm    = {ins[31:12], 12'h000};
         end
         rv_isa_pkg::OPC_AUIPC: begin
            e.op1_sel = 1'b1;
            e.imm     = {ins[31:12], 12'h000};
         end
         rv_isa_pkg::OPC_JAL: begin
            e.op1_sel = 1'b1;
            e.wb_sel  = id_ctrl_pkg::WB_PC4;
            e.bj_op   = id_ctrl_pkg::BJ_JAL;
            e.imm     = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         rv_isa_pkg::OPC_JALR: begin
            e.wb_sel = id_ctrl_pkg::WB_PC4;
            e.bj_op  = id_ctrl_pkg::BJ_JALR;
         end
         rv_isa_pkg::OPC_BRANCH: begin
            e.op2_sel   = 1'b0;
            e.reg_wb_en = 1'b0;
            e.bj_op     = id_ctrl_pkg::BJ_BRANCH;
            e.imm       = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         rv_isa_pkg::OPC_LOAD: begin
            e.wb_sel  = id_ctrl_pkg::WB_MEM;
            e.is_load = 1'b1;
         end
         rv_isa_pkg::OPC_STORE: begin
            e.reg_wb_en = 1'b0;
            e.is_store  = 1'b1;
            e.imm       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         end
         rv_isa_pkg::OPC_OPIMM: e.alu_op = arith;
         rv_isa_pkg::OPC_OP: begin
            e.alu_op  = arith;
            e.op2_sel = 1'b0;
         end
         default: begin  // All-zero control
            e.op2_sel    = 1'b0;
            e.reg_wb_en  = 1'b0;
            e.mem_funct3 = 3'd0;
         end
      endcase
      return e;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         value_errors++;
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_outputs(input stage_out_t e);
      check_value("pc_o", pc_o, e.pc);
      check_value("rs1_value_o", rs1_value_o, e.rs1_value);
      check_value("rs2_value_o", rs2_value_o, e.rs2_value);
      check_value("imm_value_o", imm_value_o, e.imm);
      check_value("rd_o", 32'(rd_o), 32'(e.rd));
      check_value("rs1_label_o", 32'(rs1_label_o), 32'(e.rs1_label));
      check_value("rs2_label_o", 32'(rs2_label_o), 32'(e.rs2_label));
      check_value("alu_op_o", 32'(alu_op_o), 32'(e.alu_op));
      check_value("alu_op1_sel_o", 32'(alu_op1_sel_o), 32'(e.op1_sel));
      check_value("alu_op2_sel_o", 32'(alu_op2_sel_o), 32'(e.op2_sel));
      check_value("wb_sel_o", 32'(wb_sel_o), 32'(e.wb_sel));
      check_value("reg_wb_en_o", 32'(reg_wb_en_o), 32'(e.reg_wb_en));
      check_value("is_load_o", 32'(is_load_o), 32'(e.is_load));
      check_value("is_store_o", 32'(is_store_o), 32'(e.is_store));
      check_value("mem_funct3_o", 32'(mem_funct3_o), 32'(e.mem_funct3));
      check_value("branch_jump_op_o", 32'(branch_jump_op_o), 32'(e.bj_op));
   endtask

   ////////////////////////////////////////
   // Compare, one cycle behind the inputs
   ////////////////////////////////////////
   always @(negedge clk_i) begin : compare
      exp_hazard = exp_out.is_load && (exp_out.rd != 5'd0) &&
                   ((exp_out.rd == instr_i[19:15]) || (exp_out.rd == instr_i[24:20]));
      if (exp_valid) begin
         compare_outputs(exp_out);
         check_value("load_stall_o", 32'(load_stall_o), 32'(exp_hazard));
      end
      // Write lands on the capture edge, so reads see it already
      if (rst_i) begin
         for (int k = 0; k < 32; k++) begin
            shadow[k] = 32'd0;
         end
      end else if (rd_enable_i && rd_label_i != 5'd0) begin
         shadow[rd_label_i] = rd_data_i;
      end
      if (rst_i || flush_i) begin
         exp_out = '0;
      end else if (busywait_i) begin
         exp_out = exp_out;                    // Hold
      end else if (stall_id_i && exp_hazard) begin
         exp_out = '0;                         // Bubble
      end else if (!stall_id_i) begin
         exp_out = ref_decode(instr_i, pc_i, shadow);
      end
      exp_valid = 1'b1;
   end

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////
   function automatic logic [31:0] random_instr();
      logic [31:0] w;
      w = $urandom;
      case ($urandom_range(9, 0))
         0: w[6:0] = rv_isa_pkg::OPC_LUI;
         1: w[6:0] = rv_isa_pkg::OPC_AUIPC;
         2: w[6:0] = rv_isa_pkg::OPC_JAL;
         3: w[6:0] = rv_isa_pkg::OPC_JALR;
         4: w[6:0] = rv_isa_pkg::OPC_BRANCH;
         5: w[6:0] = rv_isa_pkg::OPC_LOAD;
         6: w[6:0] = rv_isa_pkg::OPC_STORE;
         7: w[6:0] = rv_isa_pkg::OPC_OPIMM;
         8: w[6:0] = rv_isa_pkg::OPC_OP;
         default: w[1:0] = 2'b01;  // No supported opcode ends in 01
      endcase
      return w;
   endfunction

   function automatic logic outputs_all_zero();
      return {pc_o, rs1_value_o, rs2_value_o, imm_value_o, rd_o, rs1_label_o, rs2_label_o,
              alu_op_o, alu_op1_sel_o, alu_op2_sel_o, wb_sel_o, reg_wb_en_o, is_load_o,
              is_store_o, mem_funct3_o, branch_jump_op_o} == '0;
   endfunction

   task automatic random_writeback();
      logic [31:0] r;
      r = $urandom;
      rd_enable_i <= r[0];
      rd_label_i  <= r[5:1];
      rd_data_i   <= $urandom;
   endtask

   task automatic regfile_cycle();
      logic [31:0] r;
      logic [31:0] w;
      r = $urandom;
      w = $urandom;
      if (r[15:13] == 3'd0) begin
         r[5:1] = 5'd0;            // Extra traffic on x0
      end
      w[6:0] = rv_isa_pkg::OPC_OP;
      if (r[8]) begin
         w[19:15] = r[5:1];        // Read the register being written
      end
      if (r[9]) begin
         w[24:20] = r[5:1];
      end
      @(posedge clk_i);
      rd_enable_i <= r[0] | r[10];
      rd_label_i  <= r[5:1];
      rd_data_i   <= $urandom;
      instr_i     <= w;
      pc_i        <= $urandom;
   endtask

   task automatic traffic_cycle(input logic with_ctrl);
      logic [31:0] r;
      r = $urandom;
      @(posedge clk_i);
      busywait_i <= with_ctrl && (r[2:0] == 3'd0);
      stall_id_i <= with_ctrl && (r[5:3] < 3'd2);
      flush_i    <= with_ctrl && (r[9:6] == 4'd0);
      instr_i    <= random_instr();
      pc_i       <= $urandom;
      random_writeback();
   endtask

   task automatic load_use_round(input logic [4:0] rd);
      logic [31:0] ld;
      logic [31:0] dep;
      ld  = $urandom;
      dep = random_instr();
      ld[6:0]  = rv_isa_pkg::OPC_LOAD;
      ld[11:7] = rd;
      if (ld[31]) begin
         dep[19:15] = rd;
      end else begin
         dep[24:20] = rd;
      end
      @(posedge clk_i);
      instr_i    <= ld;
      stall_id_i <= 1'b0;
      @(posedge clk_i);            // Load enters EX
      instr_i    <= dep;
      stall_id_i <= 1'b1;
      @(negedge clk_i);
      if (load_stall_o !== (rd != 5'd0)) begin
         other_errors++;
         $display("load-use stall flag wrong at %0t for a load into x%0d", $time, rd);
      end
      @(posedge clk_i);
      stall_id_i <= 1'b0;
      @(negedge clk_i);
      if (rd != 5'd0 && !outputs_all_zero()) begin
         other_errors++;
         $display("load-use bubble left nonzero ID/EX outputs at %0t", $time);
      end
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////
   initial begin
      void'($urandom(SEED));
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_i <= 1'b0;
      repeat (RF_CYCLES) regfile_cycle();
      repeat (DEC_CYCLES) traffic_cycle(1'b0);   // Decode and immediates
      @(posedge clk_i);
      rd_enable_i <= 1'b0;
      for (int n = 0; n < LU_ROUNDS; n++) begin
         load_use_round((n % 4 == 3) ? 5'd0 : 5'(n % 31 + 1));
      end
      repeat (CTRL_CYCLES) traffic_cycle(1'b1);
      @(posedge clk_i);
      rst_i      <= 1'b1;
      busywait_i <= 1'b1;                        // Reset outranks hold
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      if (!outputs_all_zero()) begin
         other_errors++;
         $display("ID/EX outputs not cleared by reset at %0t", $time);
      end
      @(posedge clk_i);
      rst_i      <= 1'b0;
      busywait_i <= 1'b0;
      repeat (20) traffic_cycle(1'b1);
      repeat (2) @(negedge clk_i);
      #1;
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("watchdog expired before the stimulus finished");
      $display("test failed");
      $finish;
   end

endmodule

// File: vlog.f
hdl/rv_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/id_bus_if.sv
hdl/main_decoder.sv
hdl/imm_gen.sv
hdl/regfile.sv
hdl/id_ex_reg.sv
hdl/instruction_decode_stage.sv
testbench/tb_instruction_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
   --top-module tb_instruction_decode_stage -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -x "test passed" > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
